//--- include/fir_macros.svh
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// filter size
`define FIR_TAPS 32
`define FIR_DECIM 4

// word widths, samples and coefficients are Q1.15
`define FIR_SAMPLE_W 16
`define FIR_COEFF_W 16
`define FIR_ACC_W 40

// twice the taps so late writes never hit the live window
`define FIR_RING_DEPTH 64

`endif

//--- rtl/fir_types_pkg.sv
`include "fir_macros.svh"

package fir_types_pkg;

  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`FIR_COEFF_W-1:0] coeff_t;

  // full Q2.30 product of one tap
  typedef logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W-1:0] prod_t;

  typedef logic signed [`FIR_ACC_W-1:0] acc_t;

  // bits above the result that must all match its sign
  localparam int unsigned acc_guard_w = `FIR_ACC_W - `FIR_SAMPLE_W - `FIR_COEFF_W + 1;

  typedef struct packed {
    logic [acc_guard_w-1:0] guard;
    sample_t result;
    logic [`FIR_COEFF_W-2:0] fraction;
  } acc_fields_t;

  // one accumulator word, summed as raw and sliced as fields
  typedef union packed {
    acc_t raw;
    acc_fields_t fields;
  } acc_word_u;

  typedef logic [$clog2(`FIR_TAPS)-1:0] tap_addr_t;
  typedef logic [$clog2(`FIR_RING_DEPTH)-1:0] ring_addr_t;

endpackage

//--- rtl/fir_ctrl_pkg.sv
package fir_ctrl_pkg;

  // one coefficient write from the load port
  typedef struct packed {
    logic valid;
    fir_types_pkg::tap_addr_t addr;
    fir_types_pkg::coeff_t data;
  } coeff_wr_t;

  // one tap of the dot product
  typedef struct packed {
    logic valid;
    logic first;
    logic last;
  } mac_step_t;

endpackage

//--- rtl/coeff_bank.sv
`include "fir_macros.svh"

module coeff_bank (
  input  logic                      clk,
  input  logic                      nrst,
  input  fir_ctrl_pkg::coeff_wr_t   wr,
  input  logic                      rd_en,
  input  fir_types_pkg::tap_addr_t  rd_addr,
  output fir_types_pkg::coeff_t     coeff
);

  fir_types_pkg::coeff_t regs [`FIR_TAPS];

  // write port
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int i = 0; i < `FIR_TAPS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid) begin
      regs[wr.addr] <= wr.data;
    end
  end

  // registered read, one clock after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      coeff <= regs[rd_addr];
    end
  end

  ////////////////////////////////////////
  // checks

  // coefficients may only change between dot products
  a_no_wr_during_rd: assert property (
    @(posedge clk) disable iff (!nrst)
    rd_en |-> !wr.valid
  ) else $error("coefficient write while the sequencer is reading");

endmodule

//--- rtl/sample_ring.sv
`include "fir_macros.svh"

module sample_ring (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic                      valid_in,
  input  fir_types_pkg::sample_t    din,
  input  logic                      rd_en,
  input  fir_types_pkg::tap_addr_t  rd_back,
  output logic                      decim_tick,
  output logic                      ring_full,
  output fir_types_pkg::sample_t    sample
);

  localparam int phase_w = $clog2(`FIR_DECIM);
  localparam logic [phase_w-1:0] last_phase = phase_w'(`FIR_DECIM - 1);
  localparam int fill_w = $clog2(`FIR_TAPS + 1);
  localparam logic [fill_w-1:0] fill_max = fill_w'(`FIR_TAPS);

  fir_types_pkg::sample_t mem [`FIR_RING_DEPTH];

  fir_types_pkg::ring_addr_t wr_ptr;
  fir_types_pkg::ring_addr_t newest;
  fir_types_pkg::ring_addr_t rd_ptr;
  logic [phase_w-1:0] phase;
  logic [fill_w-1:0] fill;

  always_ff @(posedge clk) begin
    if (valid_in) begin
      mem[wr_ptr] <= din;
    end
  end

  ////////////////////////////////////////
  // pointers and decimation phase

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      wr_ptr <= '0;
      newest <= '0;
      phase <= '0;
      fill <= '0;
      decim_tick <= 1'b0;
    end else begin
      decim_tick <= 1'b0;
      if (valid_in) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (fill != fill_max) begin
          fill <= fill + 1'b1;
        end
        if (phase == last_phase) begin
          phase <= '0;
          decim_tick <= 1'b1;
          // freeze the window on the sample just written
          newest <= wr_ptr;
        end else begin
          phase <= phase + 1'b1;
        end
      end
    end
  end

  assign ring_full = (fill == fill_max);

  // tap k reads k samples behind the newest
  assign rd_ptr = newest - fir_types_pkg::ring_addr_t'(rd_back);

  always_ff @(posedge clk) begin
    if (rd_en) begin
      sample <= mem[rd_ptr];
    end
  end

endmodule

//--- rtl/tap_sequencer.sv
`include "fir_macros.svh"

module tap_sequencer (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic                      decim_tick,
  output logic                      rd_en,
  output fir_types_pkg::tap_addr_t  tap_addr,
  output fir_ctrl_pkg::mac_step_t   step
);

  localparam fir_types_pkg::tap_addr_t last_tap = fir_types_pkg::tap_addr_t'(`FIR_TAPS - 1);

  logic busy;
  fir_types_pkg::tap_addr_t tap_cnt;
  fir_ctrl_pkg::mac_step_t issued;

  ////////////////////////////////////////
  // tap walker

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      busy <= 1'b0;
      tap_cnt <= '0;
    end else if (decim_tick) begin
      busy <= 1'b1;
      tap_cnt <= '0;
    end else if (busy) begin
      if (tap_cnt == last_tap) begin
        busy <= 1'b0;
        tap_cnt <= '0;
      end else begin
        tap_cnt <= tap_cnt + 1'b1;
      end
    end
  end

  // both stores see the same address
  assign rd_en = busy;
  assign tap_addr = tap_cnt;

  always_comb begin
    issued.valid = busy;
    issued.first = busy && (tap_cnt == '0);
    issued.last = busy && (tap_cnt == last_tap);
  end

  // one register to match the read latency of the stores
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      step <= '0;
    end else begin
      step <= issued;
    end
  end

  ////////////////////////////////////////
  // checks

  // input rate rule, a group must not end before the walk is done
  a_tick_when_idle: assert property (
    @(posedge clk) disable iff (!nrst)
    decim_tick |-> !busy
  ) else $error("decimation tick while taps are still being walked");

endmodule

//--- rtl/mac_round_sat.sv
`include "fir_macros.svh"

module mac_round_sat (
  input  logic                     clk,
  input  logic                     nrst,
  input  fir_ctrl_pkg::mac_step_t  step,
  input  fir_types_pkg::sample_t   sample,
  input  fir_types_pkg::coeff_t    coeff,
  input  logic                     ring_full,
  output logic                     valid_out,
  output fir_types_pkg::sample_t   dout
);

  // half an output lsb, below bit 15
  localparam fir_types_pkg::acc_t round_half =
    fir_types_pkg::acc_t'(1) <<< (`FIR_COEFF_W - 2);
  localparam fir_types_pkg::sample_t sat_max = {1'b0, {(`FIR_SAMPLE_W-1){1'b1}}};
  localparam fir_types_pkg::sample_t sat_min = {1'b1, {(`FIR_SAMPLE_W-1){1'b0}}};

  fir_types_pkg::prod_t product;
  fir_types_pkg::acc_t acc_next;
  fir_types_pkg::acc_word_u acc;
  fir_types_pkg::sample_t sat_val;
  logic done;
  logic in_dot;

  ////////////////////////////////////////
  // multiply-accumulate

  assign product = sample * coeff;

  always_comb begin
    if (step.first) begin
      acc_next = fir_types_pkg::acc_t'(product);
    end else begin
      acc_next = acc.raw + fir_types_pkg::acc_t'(product);
    end
    if (step.last) begin
      acc_next = acc_next + round_half;
    end
  end

  always_ff @(posedge clk) begin
    if (step.valid) begin
      acc.raw <= acc_next;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      done <= 1'b0;
      in_dot <= 1'b0;
    end else begin
      done <= step.valid && step.last;
      if (step.valid && step.last) begin
        in_dot <= 1'b0;
      end else if (step.valid && step.first) begin
        in_dot <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // rounding output and saturation

  always_comb begin
    if (acc.fields.guard ==
        {fir_types_pkg::acc_guard_w{acc.fields.result[`FIR_SAMPLE_W-1]}}) begin
      sat_val = acc.fields.result;
    end else if (acc.fields.guard[fir_types_pkg::acc_guard_w-1]) begin
      sat_val = sat_min;
    end else begin
      sat_val = sat_max;
    end
  end

  // nothing leaves until the window holds real samples
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      valid_out <= 1'b0;
      dout <= '0;
    end else begin
      valid_out <= done && ring_full;
      if (done && ring_full) begin
        dout <= sat_val;
      end
    end
  end

  a_last_after_first: assert property (
    @(posedge clk) disable iff (!nrst)
    (step.valid && step.last) |-> (step.first || in_dot)
  ) else $error("last tap without a first tap");

endmodule

//--- rtl/fir_decimator_top.sv
module fir_decimator_top (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic                      valid_in,
  input  fir_types_pkg::sample_t    din,
  input  logic                      c_we,
  input  fir_types_pkg::tap_addr_t  c_addr,
  input  fir_types_pkg::coeff_t     c_in,
  output logic                      valid_out,
  output fir_types_pkg::sample_t    dout
);

  fir_ctrl_pkg::coeff_wr_t coeff_wr;
  fir_ctrl_pkg::mac_step_t step;
  fir_types_pkg::tap_addr_t tap_addr;
  fir_types_pkg::coeff_t coeff;
  fir_types_pkg::sample_t sample;
  logic rd_en;
  logic decim_tick;
  logic ring_full;

  assign coeff_wr = '{valid: c_we, addr: c_addr, data: c_in};

  ////////////////////////////////////////
  // input side

  coeff_bank u_coeff_bank (
    .clk     (clk),
    .nrst    (nrst),
    .wr      (coeff_wr),
    .rd_en   (rd_en),
    .rd_addr (tap_addr),
    .coeff   (coeff)
  );

  sample_ring u_sample_ring (
    .clk        (clk),
    .nrst       (nrst),
    .valid_in   (valid_in),
    .din        (din),
    .rd_en      (rd_en),
    .rd_back    (tap_addr),
    .decim_tick (decim_tick),
    .ring_full  (ring_full),
    .sample     (sample)
  );

  ////////////////////////////////////////
  // processing and output

  tap_sequencer u_tap_sequencer (
    .clk        (clk),
    .nrst       (nrst),
    .decim_tick (decim_tick),
    .rd_en      (rd_en),
    .tap_addr   (tap_addr),
    .step       (step)
  );

  mac_round_sat u_mac_round_sat (
    .clk       (clk),
    .nrst      (nrst),
    .step      (step),
    .sample    (sample),
    .coeff     (coeff),
    .ring_full (ring_full),
    .valid_out (valid_out),
    .dout      (dout)
  );

endmodule

//--- verification/fir_decimator_tb.sv
`include "fir_macros.svh"

module fir_decimator_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic nrst;
  logic valid_in;
  fir_types_pkg::sample_t din;
  logic c_we;
  fir_types_pkg::tap_addr_t c_addr;
  fir_types_pkg::coeff_t c_in;
  logic valid_out;
  fir_types_pkg::sample_t dout;

  int seed = 32'h0076_5844;
  int cyc = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int out_cnt = 0;
  int strobes = 0;
  bit loaded = 0;
  longint limit_ns;

  int t_id[$], t_cmode[$], t_tap[$], t_cnt[$], t_amode[$];
  int coef[`FIR_TAPS];
  int hist[$];
  int exp_q[$];
  int due_q[$];

  fir_decimator_top DUT (
    .clk       (clk),
    .nrst      (nrst),
    .valid_in  (valid_in),
    .din       (din),
    .c_we      (c_we),
    .c_addr    (c_addr),
    .c_in      (c_in),
    .valid_out (valid_out),
    .dout      (dout)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // reference model

  function automatic int filter_output();
    longint acc;
    longint lim_hi;
    longint lim_lo;
    acc = 0;
    lim_hi = (longint'(1) <<< (`FIR_SAMPLE_W - 1)) - 1;
    lim_lo = -(longint'(1) <<< (`FIR_SAMPLE_W - 1));
    for (int k = 0; k < `FIR_TAPS; k++) begin
      acc += longint'(coef[k]) * longint'(hist[hist.size() - 1 - k]);
    end
    // round half up at the output lsb
    acc = (acc + (longint'(1) <<< (`FIR_COEFF_W - 2))) >>> (`FIR_COEFF_W - 1);
    if (acc > lim_hi) begin
      acc = lim_hi;
    end else if (acc < lim_lo) begin
      acc = lim_lo;
    end
    return int'(acc);
  endfunction

  always @(negedge clk) begin
    if (nrst && valid_out) begin
      if (exp_q.size() == 0) begin
        $display("%0t: valid_out pulsed when no output was expected", $time);
        fail_cnt++;
      end else begin
        check_value("dout", exp_q.pop_front(), int'(dout));
        check_value("valid_out cycle", due_q.pop_front(), cyc);
        out_cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus

  task automatic load_tests(output bit ok);
    int fd;
    int id, cm, tp, cnt, am;
    string line;
    fd = $fopen("verification/fir_tests.dat", "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%d %d %d %d %d", id, cm, tp, cnt, am) == 5) begin
            t_id.push_back(id);
            t_cmode.push_back(cm);
            t_tap.push_back(tp);
            t_cnt.push_back(cnt);
            t_amode.push_back(am);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_coeffs(input int mode, input int tap);
    for (int k = 0; k < `FIR_TAPS; k++) begin
      if (mode == 0) begin
        coef[k] = (k == tap) ? 32767 : 0;
      end else if (mode == 1) begin
        coef[k] = $random(seed) % 4096;
      end else begin
        coef[k] = 32767;
      end
      @(negedge clk);
      c_we = 1'b1;
      c_addr = k[4:0];
      c_in = coef[k][15:0];
    end
    @(negedge clk);
    c_we = 1'b0;
  endtask

  task automatic send_sample(input int amode);
    int r;
    logic signed [15:0] v;
    r = $random(seed);
    v = r[15:0];
    if (amode == 1) begin
      v = 16'sh7fff;
    end else if (amode == 2) begin
      v = 16'sh8000;
    end
    @(negedge clk);
    valid_in = 1'b1;
    din = v;
    hist.push_back(int'(v));
    strobes++;
    // every M-th strobe ends a group, output only once the window is filled
    if (strobes % `FIR_DECIM == 0 && strobes >= `FIR_TAPS) begin
      exp_q.push_back(filter_output());
      due_q.push_back(cyc + 1 + `FIR_TAPS + 3);
    end
    @(negedge clk);
    valid_in = 1'b0;
    repeat (8) @(negedge clk);
  endtask

  task automatic run_test(input int i);
    int fails_before;
    int outs_before;
    fails_before = fail_cnt;
    outs_before = out_cnt;
    write_coeffs(t_cmode[i], t_tap[i]);
    for (int n = 0; n < t_cnt[i]; n++) begin
      send_sample(t_amode[i]);
    end
    repeat (`FIR_TAPS + 8) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("test %0d: %0d expected outputs never appeared", t_id[i], exp_q.size());
      fail_cnt++;
      exp_q.delete();
      due_q.delete();
    end
    $display("test %0d: %0d outputs checked, %0d failures", t_id[i],
             out_cnt - outs_before, fail_cnt - fails_before);
  endtask

  initial begin
    bit ok;
    longint total;
    nrst = 1'b0;
    valid_in = 1'b0;
    din = '0;
    c_we = 1'b0;
    c_addr = '0;
    c_in = '0;
    load_tests(ok);
    if (!ok || t_id.size() == 0) begin
      $display("could not read any test from verification/fir_tests.dat");
      $display("Testbench failed");
      $finish;
    end else begin
      total = 0;
      foreach (t_cnt[i]) begin
        total += t_cnt[i];
      end
      limit_ns = total * 10 * 20 + longint'(t_id.size()) * 120 * 20 + 2000;
      loaded = 1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      nrst = 1'b1;
      foreach (t_id[i]) begin
        run_test(i);
      end
      $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

  // watchdog
  initial begin
    wait (loaded);
    #(limit_ns);
    $display("timeout: test sequence did not finish within %0d ns", limit_ns);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
rtl/fir_types_pkg.sv
rtl/fir_ctrl_pkg.sv
rtl/coeff_bank.sv
rtl/sample_ring.sv
rtl/tap_sequencer.sv
rtl/mac_round_sat.sv
rtl/fir_decimator_top.sv
verification/fir_decimator_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fir_decimator_tb -f vlog.f -o fir_sim

./obj_dir/fir_sim 2>&1 | tee sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

//--- verification/fir_tests.dat
# id cmode tap count amode
# cmode 0 unit tap at column tap, 1 random, 2 all max; amode 0 random, 1 +full, 2 -full
1 0 0 40 0
2 0 5 24 0
3 0 31 36 0
4 1 0 48 0
5 1 0 32 0
6 2 0 40 1
7 2 0 40 2
8 0 17 20 0
9 1 0 22 0
10 0 3 26 0
